/* compile.f */
rtl/serial_link_pkg.sv
rtl/serial_link_regs.sv
rtl/serial_link_raw_fifo.sv
rtl/serial_link_phy_tx.sv
rtl/serial_link_phy_rx.sv
rtl/serial_link.sv
verification/tb_serial_link.sv

/* run_sim.sh */
#!/bin/sh
# Builds the serial link testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_serial_link -o tb_serial_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_serial_link)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test passed$"; then
  exit 0
fi
exit 1

/* verification/tb_serial_link.sv */
/*
  Self-checking testbench for the raw-mode serial link.
  The lanes and the forwarded clock loop back from the transmit side to the
  receive side, so words pushed over APB return through the receive FIFO.
  Runs reset, control, loopback, divider and FIFO tests and prints a line
  per test followed by a count line.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_serial_link import serial_link_pkg::*; ();

  localparam int unsigned WaitLimit = 500;

  logic       clk;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata;
  logic       pready;
  apb_data_t  prdata;
  logic       pslverr;
  logic       fwd_clk;
  phy_data_t  lanes;
  logic [1:0] isolated;
  logic [1:0] isolate;
  logic       clk_ena;
  logic       reset_n;

  int unsigned checks       = 0;
  int unsigned errors       = 0;
  logic        timed_out    = 1'b0;
  logic [15:0] lfsr_q       = 16'd49712;
  int unsigned fwd_rises    = 0;
  logic        fwd_clk_prev = 1'b0;

  serial_link UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .pready_o      (pready),
    .prdata_o      (prdata),
    .pslverr_o     (pslverr),
    .ddr_rcv_clk_i (fwd_clk),
    .ddr_rcv_clk_o (fwd_clk),
    .ddr_i         (lanes),
    .ddr_o         (lanes),
    .isolated_i    (isolated),
    .isolate_o     (isolate),
    .clk_ena_o     (clk_ena),
    .reset_n_o     (reset_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Counts rising edges of the forwarded clock, one per word sent
  always @(negedge clk) begin
    if (fwd_clk && !fwd_clk_prev) begin
      fwd_rises <= fwd_rises + 1;
    end
    fwd_clk_prev <= fwd_clk;
  end

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  function automatic void check_value(string name, apb_data_t exp, apb_data_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endfunction

  function automatic void report_assertion(string what);
    errors++;
    $display("Assertion failed at %0t ns: %s", $time, what);
  endfunction

  function automatic void note_timeout(string what);
    if (!timed_out) begin
      timed_out = 1'b1;
      errors++;
      $display("Timed out while waiting for %s", what);
    end
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    // Taps 16, 14, 13, 11
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_value(input int unsigned nbits, output apb_data_t v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[15]};
    end
  endtask

  task automatic report_test(input string name, input int unsigned err0);
    if (errors == err0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d error(s)", name, errors - err0);
    end
  endtask

  pready_always_high: assert property (
    @(posedge clk) disable iff (!rst_n) pready
  ) else report_assertion("pready_o went low");

  slverr_only_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) !(psel && penable) |-> !pslverr
  ) else report_assertion("pslverr_o high outside an access phase");

  // Lanes may only change together with a low forwarded clock
  lanes_change_on_low_clk: assert property (
    @(posedge clk) disable iff (!rst_n) !$stable(lanes) |-> !fwd_clk
  ) else report_assertion("lanes changed while the forwarded clock was high");

  ////////////////////////////////////////////////////////////
  // APB and wait tasks
  ////////////////////////////////////////////////////////////

  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int unsigned waited;
    logic        done;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    done   = 1'b0;
    waited = 0;
    while (!done && waited < WaitLimit) begin
      @(negedge clk);
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        waited++;
      end
      @(posedge clk);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
    if (!done) begin
      note_timeout("pready_o");
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, wdata, rd, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
  endtask

  task automatic wait_rx_valid();
    apb_data_t   rd;
    int unsigned tries;
    rd    = '0;
    tries = 0;
    while (rd[0] !== 1'b1 && tries < WaitLimit && !timed_out) begin
      apb_read(AddrRawInValid, rd);
      tries++;
    end
    if (rd[0] !== 1'b1) begin
      note_timeout("a word in the receive FIFO");
    end
  endtask

  task automatic wait_fwd_rises(input int unsigned target);
    int unsigned waited;
    waited = 0;
    while (fwd_rises < target && waited < WaitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (fwd_rises < target) begin
      note_timeout("forwarded clock edges");
    end
  endtask

  task automatic measure_high_time(output int unsigned cycles);
    int unsigned waited;
    cycles = 0;
    waited = 0;
    @(negedge clk);
    while (!fwd_clk && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    while (fwd_clk && cycles < WaitLimit) begin
      cycles++;
      @(negedge clk);
    end
    if (waited >= WaitLimit || cycles >= WaitLimit) begin
      note_timeout("the forwarded clock");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    apb_data_t   rd;
    int unsigned err0;
    err0 = errors;
    apb_read(AddrCtrl, rd);
    check_value("reset_ctrl", 32'h0000_0303, rd);
    apb_read(AddrClkDiv, rd);
    check_value("reset_clk_div", 32'd4, rd);
    apb_read(AddrRawOutCtrl, rd);
    check_value("reset_raw_out_ctrl", 32'd0, rd);
    apb_read(AddrRawInValid, rd);
    check_value("reset_raw_in_valid", 32'd0, rd);
    @(negedge clk);
    check_value("reset_isolate_o", 32'd3, 32'(isolate));
    check_value("reset_clk_ena_o", 32'd1, 32'(clk_ena));
    check_value("reset_reset_n_o", 32'd1, 32'(reset_n));
    check_value("reset_fwd_clk", 32'd0, 32'(fwd_clk));
    check_value("reset_lanes", 32'd0, 32'(lanes));
    report_test("reset_values", err0);
  endtask

  task automatic test_ctrl_status();
    apb_data_t   v;
    apb_data_t   rd;
    int unsigned err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      random_value(32, v);
      apb_write(AddrCtrl, v);
      @(negedge clk);
      check_value("ctrl_isolate_o", 32'({v[9], v[8]}), 32'(isolate));
      check_value("ctrl_clk_ena_o", 32'(v[0]), 32'(clk_ena));
      check_value("ctrl_reset_n_o", 32'(v[1]), 32'(reset_n));
      apb_read(AddrCtrl, rd);
      check_value("ctrl_readback", v & 32'h0000_0303, rd);
    end
    apb_write(AddrCtrl, 32'h0000_0303);
    @(posedge clk);
    isolated <= 2'b10;
    apb_read(AddrIsolated, rd);
    check_value("isolated_readback", 32'd2, rd);
    @(posedge clk);
    isolated <= 2'b01;
    apb_read(AddrIsolated, rd);
    check_value("isolated_readback", 32'd1, rd);
    report_test("ctrl_status", err0);
  endtask

  task automatic test_loopback();
    logic [7:0]  sent[$];
    logic [7:0]  exp;
    apb_data_t   v;
    apb_data_t   rd;
    int unsigned err0;
    err0 = errors;
    apb_write(AddrRawModeEn, 32'd1);
    for (int i = 0; i < 5; i++) begin
      random_value(8, v);
      sent.push_back(v[7:0]);
      apb_write(AddrRawOutData, v);
    end
    apb_read(AddrRawOutCtrl, rd);
    check_value("loopback_fill", 32'h0000_0500, rd);
    apb_write(AddrRawOutEn, 32'd1);
    while (sent.size() > 0 && !timed_out) begin
      exp = sent.pop_front();
      wait_rx_valid();
      apb_read(AddrRawInData, rd);
      check_value("loopback_data", 32'(exp), rd);
    end
    apb_write(AddrRawOutEn, 32'd0);
    report_test("raw_loopback", err0);
  endtask

  task automatic test_divider();
    apb_data_t   v;
    apb_data_t   rd;
    int unsigned high;
    int unsigned err0;
    err0 = errors;
    apb_write(AddrClkDiv, 32'd8);
    apb_read(AddrClkDiv, rd);
    check_value("divider_readback", 32'd8, rd);
    random_value(8, v);
    apb_write(AddrRawOutData, v);
    apb_write(AddrRawOutEn, 32'd1);
    measure_high_time(high);
    check_value("divider_high_time", 32'd4, 32'(high));
    wait_rx_valid();
    apb_read(AddrRawInData, rd);
    check_value("divider_data", v, rd);
    apb_write(AddrRawOutEn, 32'd0);
    // Odd values lose bit 0
    apb_write(AddrClkDiv, 32'd5);
    apb_read(AddrClkDiv, rd);
    check_value("divider_odd_write", 32'd4, rd);
    report_test("divider", err0);
  endtask

  task automatic test_full_clear();
    apb_data_t   v;
    apb_data_t   rd;
    logic        err;
    int unsigned target;
    int unsigned err0;
    err0 = errors;
    for (int i = 0; i < 9; i++) begin
      random_value(8, v);
      apb_write(AddrRawOutData, v);
    end
    apb_read(AddrRawOutCtrl, rd);
    check_value("tx_fifo_full", 32'h8000_0800, rd);
    apb_write(AddrRawOutCtrl, 32'd1);
    apb_read(AddrRawOutCtrl, rd);
    check_value("tx_fifo_clear", 32'd0, rd);

    // Fill the receive FIFO over the loopback
    target = fwd_rises + 8;
    for (int i = 0; i < 8; i++) begin
      random_value(8, v);
      apb_write(AddrRawOutData, v);
    end
    apb_write(AddrRawOutEn, 32'd1);
    wait_fwd_rises(target);
    // Push lands three cycles after the edge, plus one for the FIFO write
    repeat (4) @(posedge clk);
    apb_write(AddrRawOutEn, 32'd0);
    apb_read(AddrRawInValid, rd);
    check_value("rx_fifo_filled", 32'd1, rd);
    apb_write(AddrFlowFifoClear, 32'd1);
    apb_read(AddrRawInValid, rd);
    check_value("rx_fifo_clear", 32'd0, rd);

    apb_access(1'b0, 6'h3C, '0, rd, err);
    check_value("unmapped_pslverr", 32'd1, 32'(err));
    apb_access(1'b1, AddrRawInValid, 32'd1, rd, err);
    check_value("read_only_pslverr", 32'd1, 32'(err));
    apb_access(1'b0, AddrCtrl, '0, rd, err);
    check_value("mapped_pslverr", 32'd0, 32'(err));
    report_test("fifo_full_clear", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n    <= 1'b0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    isolated <= 2'b00;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    test_reset_values();
    if (!timed_out) begin
      test_ctrl_status();
    end
    if (!timed_out) begin
      test_loopback();
    end
    if (!timed_out) begin
      test_divider();
    end
    if (!timed_out) begin
      test_full_clear();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/serial_link.sv */
/*
  Top level of the raw-mode serial link.
  APB configures the link and moves words through a transmit FIFO and a
  receive FIFO; the physical halves drive and sample the eight lanes and
  the forwarded clock.
*/
`timescale 1ns/1ns
`default_nettype none

module serial_link import serial_link_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire logic       psel_i,
  input  wire logic       penable_i,
  input  wire logic       pwrite_i,
  input  wire apb_addr_t  paddr_i,
  input  wire apb_data_t  pwdata_i,
  output logic            pready_o,
  output apb_data_t       prdata_o,
  output logic            pslverr_o,
  input  wire logic       ddr_rcv_clk_i,
  output logic            ddr_rcv_clk_o,
  input  wire phy_data_t  ddr_i,
  output phy_data_t       ddr_o,
  input  wire logic [1:0] isolated_i,
  output logic [1:0]      isolate_o,
  output logic            clk_ena_o,
  output logic            reset_n_o
);

  clk_div_t  clk_div;
  logic      raw_mode_en;
  logic      raw_out_en;
  logic      tx_push;
  phy_data_t tx_wdata;
  logic      tx_clear;
  fill_t     tx_fill;
  logic      tx_full;
  logic      tx_empty;
  phy_data_t tx_head;
  logic      tx_pop;
  logic      rx_push;
  phy_data_t rx_wdata;
  logic      rx_pop;
  logic      rx_clear;
  phy_data_t rx_head;
  logic      rx_empty;

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  serial_link_regs u_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .pready_o      (pready_o),
    .prdata_o      (prdata_o),
    .pslverr_o     (pslverr_o),
    .isolated_i    (isolated_i),
    .isolate_o     (isolate_o),
    .clk_ena_o     (clk_ena_o),
    .reset_n_o     (reset_n_o),
    .clk_div_o     (clk_div),
    .raw_mode_en_o (raw_mode_en),
    .raw_out_en_o  (raw_out_en),
    .tx_push_o     (tx_push),
    .tx_wdata_o    (tx_wdata),
    .tx_clear_o    (tx_clear),
    .tx_fill_i     (tx_fill),
    .tx_full_i     (tx_full),
    .rx_pop_o      (rx_pop),
    .rx_clear_o    (rx_clear),
    .rx_data_i     (rx_head),
    .rx_empty_i    (rx_empty)
  );

  ////////////////////////////////////////////////////////////
  // Raw-mode FIFOs
  ////////////////////////////////////////////////////////////

  serial_link_raw_fifo u_tx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (tx_clear),
    .push_i  (tx_push),
    .data_i  (tx_wdata),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .fill_o  (tx_fill),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  // Receive fill level and full flag are not exposed
  serial_link_raw_fifo u_rx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (rx_clear),
    .push_i  (rx_push),
    .data_i  (rx_wdata),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .fill_o  (),
    .full_o  (),
    .empty_o (rx_empty)
  );

  ////////////////////////////////////////////////////////////
  // Physical layer
  ////////////////////////////////////////////////////////////

  serial_link_phy_tx u_phy_tx (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .en_i          (raw_out_en),
    .clk_div_i     (clk_div),
    .data_i        (tx_head),
    .empty_i       (tx_empty),
    .pop_o         (tx_pop),
    .ddr_o         (ddr_o),
    .ddr_rcv_clk_o (ddr_rcv_clk_o)
  );

  serial_link_phy_rx u_phy_rx (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .en_i          (raw_mode_en),
    .ddr_i         (ddr_i),
    .ddr_rcv_clk_i (ddr_rcv_clk_i),
    .push_o        (rx_push),
    .data_o        (rx_wdata)
  );

endmodule

`default_nettype wire

/* rtl/serial_link_phy_rx.sv */
/*
  Receive half of the physical layer.
  Brings the forwarded clock and the lanes into clk_i through two flops
  each, finds rising edges of the forwarded clock and pushes the lane word
  seen with that edge. The push comes three cycles after the incoming edge.
*/
`timescale 1ns/1ns
`default_nettype none

module serial_link_phy_rx import serial_link_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      en_i,
  input  wire phy_data_t ddr_i,
  input  wire logic      ddr_rcv_clk_i,
  output logic           push_o,
  output phy_data_t      data_o
);

  logic      clk_s1_q;
  logic      clk_s2_q;
  logic      clk_s3_q;
  phy_data_t data_s1_q;
  phy_data_t data_s2_q;
  logic      rise;
  logic      push_q;
  phy_data_t word_q;

  ////////////////////////////////////////////////////////////
  // Synchronizers
  ////////////////////////////////////////////////////////////

  // Lanes go through the same depth as the clock so they stay aligned
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_s1_q  <= 1'b0;
      clk_s2_q  <= 1'b0;
      clk_s3_q  <= 1'b0;
      data_s1_q <= '0;
      data_s2_q <= '0;
    end else begin
      clk_s1_q  <= ddr_rcv_clk_i;
      clk_s2_q  <= clk_s1_q;
      clk_s3_q  <= clk_s2_q;
      data_s1_q <= ddr_i;
      data_s2_q <= data_s1_q;
    end
  end

  assign rise = clk_s2_q & ~clk_s3_q;

  ////////////////////////////////////////////////////////////
  // Word capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      push_q <= 1'b0;
    end else begin
      // Words arriving while capture is off are dropped
      push_q <= rise & en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rise) begin
      word_q <= data_s2_q;
    end
  end

  assign push_o = push_q;
  assign data_o = word_q;

endmodule

`default_nettype wire

/* rtl/serial_link_phy_tx.sv */
/*
  Transmit half of the physical layer.
  Pops one word per divider period from the transmit FIFO, holds it on the
  lanes and forwards a clock that is low for the first half of the period
  and high for the second, so the far end samples on the rising edge.
*/
`timescale 1ns/1ns
`default_nettype none

module serial_link_phy_tx import serial_link_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      en_i,
  input  wire clk_div_t  clk_div_i,
  input  wire phy_data_t data_i,
  input  wire logic      empty_i,
  output logic           pop_o,
  output phy_data_t      ddr_o,
  output logic           ddr_rcv_clk_o
);

  tx_state_e state_q, state_d;
  clk_div_t  half_q, half_d;
  clk_div_t  cnt_q, cnt_d;
  phy_data_t data_q;
  logic      clk_q;
  logic      launch;

  always_comb begin
    launch  = 1'b0;
    state_d = state_q;
    half_d  = half_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      TX_IDLE: launch = en_i & ~empty_i;
      TX_LOW: begin
        if (cnt_q == '0) begin
          state_d = TX_HIGH;
          cnt_d   = half_q - clk_div_t'(1);
        end else begin
          cnt_d = cnt_q - clk_div_t'(1);
        end
      end
      TX_HIGH: begin
        if (cnt_q == '0) begin
          // Next word follows directly, otherwise go quiet
          launch  = en_i & ~empty_i;
          state_d = TX_IDLE;
        end else begin
          cnt_d = cnt_q - clk_div_t'(1);
        end
      end
      default: state_d = TX_IDLE;
    endcase
    // Divider is sampled once per word
    if (launch) begin
      state_d = TX_LOW;
      half_d  = clk_div_i >> 1;
      cnt_d   = (clk_div_i >> 1) - clk_div_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TX_IDLE;
      half_q  <= '0;
      cnt_q   <= '0;
      data_q  <= '0;
      clk_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      half_q  <= half_d;
      cnt_q   <= cnt_d;
      clk_q   <= (state_d == TX_HIGH);
      if (launch) begin
        data_q <= data_i;
      end
    end
  end

  assign pop_o         = launch;
  assign ddr_o         = data_q;
  assign ddr_rcv_clk_o = clk_q;

  // Each half period needs at least one cycle
  tx_div_at_least_two: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_o |-> clk_div_i >= MinClkDiv
  );

endmodule

`default_nettype wire

/* rtl/serial_link_raw_fifo.sv */
/*
  Small synchronous FIFO for raw-mode words.
  Used once per direction. Pushes into a full FIFO and pops from an empty
  one are ignored, and clear empties it in one cycle ahead of both.
*/
`timescale 1ns/1ns
`default_nettype none

module serial_link_raw_fifo import serial_link_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      clear_i,
  input  wire logic      push_i,
  input  wire phy_data_t data_i,
  input  wire logic      pop_i,
  output phy_data_t      data_o,
  output fill_t          fill_o,
  output logic           full_o,
  output logic           empty_o
);

  phy_data_t                   mem [RawFifoDepth];
  logic [Log2RawFifoDepth-1:0] wr_ptr_q;
  logic [Log2RawFifoDepth-1:0] rd_ptr_q;
  fill_t                       fill_q;
  logic                        push_ok;
  logic                        pop_ok;

  assign full_o  = (fill_q == fill_t'(RawFifoDepth));
  assign empty_o = (fill_q == '0);
  assign push_ok = push_i & ~full_o & ~clear_i;
  assign pop_ok  = pop_i & ~empty_o & ~clear_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push_ok && !pop_ok) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  assign data_o = mem[rd_ptr_q];
  assign fill_o = fill_q;

  fifo_fill_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) fill_q <= fill_t'(RawFifoDepth)
  );

endmodule

`default_nettype wire

/* rtl/serial_link_regs.sv */
/*
  APB register file of the serial link.
  Zero wait states: every access completes in its access phase and a write
  takes effect on the edge that ends it. Besides the configuration
  registers it turns data and clear writes into one-cycle FIFO strobes and
  turns data reads into receive-FIFO pops.
*/
`timescale 1ns/1ns
`default_nettype none

module serial_link_regs import serial_link_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  // APB slave
  input  wire logic      psel_i,
  input  wire logic      penable_i,
  input  wire logic      pwrite_i,
  input  wire apb_addr_t paddr_i,
  input  wire apb_data_t pwdata_i,
  output logic           pready_o,
  output apb_data_t      prdata_o,
  output logic           pslverr_o,
  // Control and status
  input  wire logic [1:0] isolated_i,
  output logic [1:0]     isolate_o,
  output logic           clk_ena_o,
  output logic           reset_n_o,
  output clk_div_t       clk_div_o,
  output logic           raw_mode_en_o,
  output logic           raw_out_en_o,
  // Transmit FIFO
  output logic           tx_push_o,
  output phy_data_t      tx_wdata_o,
  output logic           tx_clear_o,
  input  wire fill_t     tx_fill_i,
  input  wire logic      tx_full_i,
  // Receive FIFO
  output logic           rx_pop_o,
  output logic           rx_clear_o,
  input  wire phy_data_t rx_data_i,
  input  wire logic      rx_empty_i
);

  logic      access;
  logic      wr_en;
  logic      rd_en;
  logic      addr_err;
  logic      ro_hit;
  clk_div_t  wr_div;

  logic       clk_ena_q;
  logic       reset_n_q;
  logic [1:0] isolate_q;
  clk_div_t   clk_div_q;
  logic       raw_mode_en_q;
  logic       raw_out_en_q;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;
  assign rd_en  = access & ~pwrite_i;

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  // Divider is kept even and never below 2
  always_comb begin
    wr_div    = pwdata_i[Log2MaxClkDiv-1:0];
    wr_div[0] = 1'b0;
    if (wr_div < MinClkDiv) begin
      wr_div = MinClkDiv;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_ena_q     <= CtrlReset[CtrlClkEnaBit];
      reset_n_q     <= CtrlReset[CtrlResetNBit];
      isolate_q     <= {CtrlReset[CtrlIsoOutBit], CtrlReset[CtrlIsoInBit]};
      clk_div_q     <= ClkDivReset;
      raw_mode_en_q <= 1'b0;
      raw_out_en_q  <= 1'b0;
    end else if (wr_en) begin
      unique case (paddr_i)
        AddrCtrl: begin
          clk_ena_q <= pwdata_i[CtrlClkEnaBit];
          reset_n_q <= pwdata_i[CtrlResetNBit];
          isolate_q <= {pwdata_i[CtrlIsoOutBit], pwdata_i[CtrlIsoInBit]};
        end
        AddrClkDiv:    clk_div_q     <= wr_div;
        AddrRawModeEn: raw_mode_en_q <= pwdata_i[0];
        AddrRawOutEn:  raw_out_en_q  <= pwdata_i[0];
        default: ;
      endcase
    end
  end

  // FIFO strobes last exactly the one-cycle access phase
  assign tx_push_o  = wr_en & (paddr_i == AddrRawOutData);
  assign tx_wdata_o = pwdata_i[NumLanes-1:0];
  assign tx_clear_o = wr_en & (paddr_i == AddrRawOutCtrl) & pwdata_i[0];
  assign rx_clear_o = wr_en & (paddr_i == AddrFlowFifoClear) & pwdata_i[0];
  assign rx_pop_o   = rd_en & (paddr_i == AddrRawInData);

  ////////////////////////////////////////////////////////////
  // Read mux and error decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    prdata_o = '0;
    addr_err = 1'b0;
    ro_hit   = 1'b0;
    unique case (paddr_i)
      AddrCtrl: begin
        prdata_o[CtrlClkEnaBit] = clk_ena_q;
        prdata_o[CtrlResetNBit] = reset_n_q;
        prdata_o[CtrlIsoInBit]  = isolate_q[0];
        prdata_o[CtrlIsoOutBit] = isolate_q[1];
      end
      AddrIsolated: begin
        prdata_o[1:0] = isolated_i;
        ro_hit        = 1'b1;
      end
      AddrClkDiv:    prdata_o[Log2MaxClkDiv-1:0] = clk_div_q;
      AddrRawModeEn: prdata_o[0] = raw_mode_en_q;
      AddrRawInValid: begin
        prdata_o[0] = ~rx_empty_i;
        ro_hit      = 1'b1;
      end
      AddrRawInData: begin
        // Empty FIFO reads as zero
        if (!rx_empty_i) begin
          prdata_o[NumLanes-1:0] = rx_data_i;
        end
        ro_hit = 1'b1;
      end
      AddrRawOutEn: prdata_o[0] = raw_out_en_q;
      AddrRawOutCtrl: begin
        prdata_o[RawOutFillLsb +: $bits(fill_t)] = tx_fill_i;
        prdata_o[RawOutFullBit]                  = tx_full_i;
      end
      AddrRawOutData, AddrFlowFifoClear: ;
      default: addr_err = 1'b1;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (addr_err | (pwrite_i & ro_hit));

  assign clk_ena_o     = clk_ena_q;
  assign reset_n_o     = reset_n_q;
  assign isolate_o     = isolate_q;
  assign clk_div_o     = clk_div_q;
  assign raw_mode_en_o = raw_mode_en_q;
  assign raw_out_en_o  = raw_out_en_q;

  // Access phase is always preceded by a selected setup phase
  apb_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
  );

endmodule

`default_nettype wire

/* rtl/serial_link_pkg.sv */
/*
  Shared definitions for the raw-mode serial link.
  Holds the lane and bus widths, the APB register map, the register reset
  values and the transmit FSM encoding. Modules pull it in with a wildcard
  import in their header.
*/
`default_nettype none

package serial_link_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////////////////////////

  localparam int unsigned NumLanes         = 8;
  localparam int unsigned Log2MaxClkDiv    = 10;
  localparam int unsigned Log2RawFifoDepth = 3;
  localparam int unsigned RawFifoDepth     = 2 ** Log2RawFifoDepth;

  typedef logic [NumLanes-1:0]         phy_data_t;
  typedef logic [5:0]                  apb_addr_t;
  typedef logic [31:0]                 apb_data_t;
  typedef logic [Log2MaxClkDiv-1:0]    clk_div_t;
  // One extra bit so a full FIFO can report 8
  typedef logic [Log2RawFifoDepth:0]   fill_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_LOW,
    TX_HIGH
  } tx_state_e;

  ////////////////////////////////////////////////////////////
  // Register map in byte offsets
  ////////////////////////////////////////////////////////////

  localparam apb_addr_t AddrCtrl          = 6'h00;
  localparam apb_addr_t AddrIsolated      = 6'h04;
  localparam apb_addr_t AddrClkDiv        = 6'h08;
  localparam apb_addr_t AddrRawModeEn     = 6'h10;
  localparam apb_addr_t AddrRawInValid    = 6'h14;
  localparam apb_addr_t AddrRawInData     = 6'h18;
  localparam apb_addr_t AddrRawOutEn      = 6'h1C;
  localparam apb_addr_t AddrRawOutData    = 6'h20;
  localparam apb_addr_t AddrRawOutCtrl    = 6'h24;
  localparam apb_addr_t AddrFlowFifoClear = 6'h28;

  // Field positions in the control and raw-out control registers
  localparam int unsigned CtrlClkEnaBit  = 0;
  localparam int unsigned CtrlResetNBit  = 1;
  localparam int unsigned CtrlIsoInBit   = 8;
  localparam int unsigned CtrlIsoOutBit  = 9;
  localparam int unsigned RawOutFillLsb  = 8;
  localparam int unsigned RawOutFullBit  = 31;

  // Reset values
  localparam apb_data_t CtrlReset   = 32'h0000_0303;
  localparam clk_div_t  ClkDivReset = 10'd4;
  localparam clk_div_t  MinClkDiv   = 10'd2;

endpackage

`default_nettype wire
